//--- compile.f
+incdir+.
cpuBusPkg.sv
cpuIsaPkg.sv
cpuAlu.sv
cpuDatapath.sv
programCounter.sv
cpuControl.sv
cpuTop.sv
cpu_chk.sv
cpuTb.sv

//--- cpuAlu.sv
`timescale 1ns/100ps

module cpuAlu (
    input  cpuBusPkg::cpuData  a,
    input  cpuBusPkg::cpuData  b,
    input  cpuIsaPkg::cpuAluOp op,
    output cpuBusPkg::cpuData  result
);
    import cpuBusPkg::*;
    import cpuIsaPkg::*;

    // Purely combinational, result valid in the same cycle as op
    always_comb begin
        case (op)
            // Arithmetic, wraps at 8 bits
            aluAdd:  result = a + b;
            aluSub:  result = a - b;
            // Bitwise logic
            aluAnd:  result = a & b;
            aluOr:   result = a | b;
            aluXor:  result = a ^ b;
            // Single bit shifts of A, zero filled
            aluShl:  result = a << 1;
            aluShr:  result = a >> 1;
            aluIncA: result = a + 1'b1;
            // Comparisons give 1 or 0
            // Used by the branch through a nonzero test
            aluEq:   result = cpuData'(a == b);
            aluGt:   result = cpuData'(a > b);
            aluLt:   result = cpuData'(a < b);
            // Anything else leaves A unchanged
            default: result = a;
        endcase
    end

endmodule

//--- cpuBusPkg.sv
`include "cpu_config.svh"

package cpuBusPkg;

    // One byte on the data bus or held in a register
    typedef logic [`CPU_DATA_WIDTH-1:0] cpuData;

    // Data bus or program ROM address
    typedef logic [`CPU_DATA_WIDTH-1:0] cpuAddr;

    // Interrupt raise or acknowledge, one bit per line
    typedef logic [`CPU_IRQ_COUNT-1:0] cpuIrq;

endpackage

//--- cpuControl.sv
`timescale 1ns/100ps

module cpuControl (
    input  logic               CLK,
    input  logic               RESET,
    input  cpuBusPkg::cpuData  romData,
    input  cpuBusPkg::cpuIrq   irqRaise,
    input  logic               branchTaken,
    output cpuIsaPkg::pcAction pcCtrl,
    output logic               offset,
    output logic               regLoadA,
    output logic               regLoadB,
    output logic               loadFromBus,
    output logic               busAddrFromRom,
    output logic               writeStrobe,
    output logic               writeSelB,
    output cpuBusPkg::cpuIrq   irqAck
);
    import cpuBusPkg::*;
    import cpuIsaPkg::*;

    cpuState  state;
    cpuState  nextState;
    // Register B selected by the current instruction
    logic     regSelB;
    logic     nextRegSelB;
    cpuIrq    nextIrqAck;
    cpuOpcode opcode;

    // Only meaningful in stChoose, where romData holds the instruction
    assign opcode = cpuOpcode'(romData[3:0]);

    // Write source follows the saved register choice
    assign writeSelB = regSelB;

    always_ff @(posedge CLK) begin
        if (RESET) begin
            state   <= stChoose;
            regSelB <= 1'b0;
            irqAck  <= '0;
        end else begin
            state   <= nextState;
            regSelB <= nextRegSelB;
            irqAck  <= nextIrqAck;
        end
    end

    always_comb begin
        // Defaults hold everything and request no action
        nextState      = state;
        nextRegSelB    = regSelB;
        nextIrqAck     = '0;
        pcCtrl         = pcHold;
        offset         = 1'b0;
        regLoadA       = 1'b0;
        regLoadB       = 1'b0;
        loadFromBus    = 1'b0;
        busAddrFromRom = 1'b0;
        writeStrobe    = 1'b0;

        case (state)
            ////////////////////////////////////////////////////////////
            // Thread start
            // Sleep here, line 0 has priority
            stIdle: begin
                pcCtrl = pcVector0;
                if (irqRaise[0]) begin
                    nextState     = stThread0;
                    nextIrqAck[0] = 1'b1;
                end else if (irqRaise[1]) begin
                    nextState     = stThread0;
                    pcCtrl        = pcVector1;
                    nextIrqAck[1] = 1'b1;
                end
            end
            // Vector byte on its way from ROM
            stThread0: nextState = stThread1;
            stThread1: begin
                pcCtrl    = pcLoadRom;
                nextState = stThread2;
            end
            // New PC settles
            stThread2: nextState = stChoose;

            ////////////////////////////////////////////////////////////
            // Decode, fetch of the address byte starts here
            stChoose: begin
                offset = 1'b1;
                // Bit 0 picks A or B for reads, writes and maths
                nextRegSelB = romData[0];
                case (opcode)
                    opReadA, opReadB:   nextState = stReadSel;
                    opWriteA, opWriteB: nextState = stWriteSel;
                    opMathA, opMathB:   nextState = stMathSave;
                    opBranch:           nextState = stBranch;
                    opGoto:             nextState = stGoto;
                    opIdle:             nextState = stIdle;
                    default:            nextState = state;
                endcase
            end

            ////////////////////////////////////////////////////////////
            // Read, address byte arrives in stRead0
            stReadSel: begin
                offset    = 1'b1;
                nextState = stRead0;
            end
            stRead0: begin
                busAddrFromRom = 1'b1;
                nextState      = stRead1;
            end
            // Step now so the next instruction is on romData in time
            stRead1: begin
                pcCtrl    = pcStep2;
                nextState = stRead2;
            end
            // Memory data now on dataIn
            stRead2: begin
                loadFromBus = 1'b1;
                regLoadA    = !regSelB;
                regLoadB    = regSelB;
                nextState   = stChoose;
            end

            // Write, strobe goes out with the address byte
            stWriteSel: begin
                pcCtrl    = pcStep2;
                nextState = stWrite0;
            end
            stWrite0: begin
                busAddrFromRom = 1'b1;
                writeStrobe    = 1'b1;
                nextState      = stChoose;
            end

            // Maths, ALU result is ready on the first cycle
            stMathSave: begin
                regLoadA  = !regSelB;
                regLoadB  = regSelB;
                pcCtrl    = pcStep1;
                nextState = stMathSettle;
            end
            stMathSettle: nextState = stChoose;

            ////////////////////////////////////////////////////////////
            // Branch on nonzero compare result
            stBranch: begin
                if (branchTaken) begin
                    nextState = stBranch0;
                end else begin
                    pcCtrl    = pcStep2;
                    nextState = stBranch1;
                end
            end
            // Target byte valid here
            stBranch0: begin
                pcCtrl    = pcLoadRom;
                nextState = stBranch1;
            end
            stBranch1: nextState = stChoose;

            // Unconditional jump
            stGoto: nextState = stGoto0;
            stGoto0: begin
                pcCtrl    = pcLoadRom;
                nextState = stGoto1;
            end
            stGoto1: nextState = stChoose;

            // Unused encodings fall back to decode
            default: nextState = stChoose;
        endcase
    end

endmodule

//--- cpuDatapath.sv
`timescale 1ns/100ps
`include "cpu_config.svh"

module cpuDatapath (
    input  logic              CLK,
    input  logic              RESET,
    input  cpuBusPkg::cpuData romData,
    input  cpuBusPkg::cpuData dataIn,
    input  logic              regLoadA,
    input  logic              regLoadB,
    input  logic              loadFromBus,
    input  logic              busAddrFromRom,
    input  logic              writeStrobe,
    input  logic              writeSelB,
    output cpuBusPkg::cpuData busAddr,
    output cpuBusPkg::cpuData dataOut,
    output logic              busWe,
    output logic              branchTaken
);
    import cpuBusPkg::*;
    import cpuIsaPkg::*;

    // Working registers
    cpuData  regA;
    cpuData  regB;
    cpuData  aluResult;
    cpuData  loadValue;
    cpuAluOp aluOp;

    ////////////////////////////////////////////////////////////
    // ALU
    // Op code is the high nibble of the byte still on romData
    assign aluOp = cpuAluOp'(romData[7:4]);

    cpuAlu alu0 (
        .a      (regA),
        .b      (regB),
        .op     (aluOp),
        .result (aluResult)
    );

    // Compare result drives the branch decision
    assign branchTaken = (aluResult != '0);

    // Register source, bus read data or ALU result
    assign loadValue = loadFromBus ? dataIn : aluResult;

    ////////////////////////////////////////////////////////////
    // Registers and bus outputs
    always_ff @(posedge CLK) begin
        if (RESET) begin
            regA    <= '0;
            regB    <= '0;
            busAddr <= `CPU_BUS_IDLE_ADDR;
            busWe   <= 1'b0;
        end else begin
            if (regLoadA) begin
                regA <= loadValue;
            end
            if (regLoadB) begin
                regB <= loadValue;
            end
            // Address byte from ROM for one cycle, idle address otherwise
            busAddr <= busAddrFromRom ? romData : `CPU_BUS_IDLE_ADDR;
            // Strobe lines up with address and data
            busWe   <= writeStrobe;
        end
    end

    // Write data only needs to be valid alongside busWe
    always_ff @(posedge CLK) begin
        if (writeStrobe) begin
            dataOut <= writeSelB ? regB : regA;
        end
    end

endmodule

//--- cpuIsaPkg.sv
package cpuIsaPkg;

    // Instruction codes from the low nibble of the instruction byte
    // Codes 9 to F are not decoded
    typedef enum logic [3:0] {
        opReadA  = 4'h0,
        opReadB  = 4'h1,
        opWriteA = 4'h2,
        opWriteB = 4'h3,
        opMathA  = 4'h4,
        opMathB  = 4'h5,
        opBranch = 4'h6,
        opGoto   = 4'h7,
        opIdle   = 4'h8
    } cpuOpcode;

    // ALU operation from the high nibble
    // Unlisted codes pass A through
    typedef enum logic [3:0] {
        aluAdd  = 4'h0,
        aluSub  = 4'h1,
        aluAnd  = 4'h2,
        aluOr   = 4'h3,
        aluXor  = 4'h4,
        aluShl  = 4'h5,
        aluShr  = 4'h6,
        aluIncA = 4'h7,
        aluEq   = 4'h8,
        aluGt   = 4'h9,
        aluLt   = 4'hA
    } cpuAluOp;

    // Instruction sequencing states
    typedef enum logic [4:0] {
        stIdle, stThread0, stThread1, stThread2,
        stChoose,
        stReadSel, stRead0, stRead1, stRead2,
        stWriteSel, stWrite0,
        stMathSave, stMathSettle,
        stBranch, stBranch0, stBranch1,
        stGoto, stGoto0, stGoto1
    } cpuState;

    // Program counter update requested by the sequencer
    typedef enum logic [2:0] {
        pcHold, pcLoadRom, pcStep1, pcStep2, pcVector0, pcVector1
    } pcAction;

endpackage

//--- cpuTb.sv
`timescale 1ns/100ps
`include "cpu_config.svh"

module cpuTb;
    import cpuBusPkg::*;
    import cpuIsaPkg::*;

    localparam int TRIALS = 40;
    // Up to 40 instructions of at most 5 cycles per trial plus a margin
    localparam int MAX_CYCLES = TRIALS * 40 * 5 + 1000;

    logic   CLK = 1'b0;
    logic   RESET;
    cpuData dataIn;
    cpuData romData;
    cpuIrq  irqRaise;
    cpuAddr busAddr;
    cpuAddr romAddress;
    cpuData dataOut;
    logic   busWe;
    cpuIrq  irqAck;

    // Memory models and reference model state
    cpuData      rom [256];
    cpuData      ram [256];
    cpuData      modelRam [256];
    cpuData      modelA = '0;
    cpuData      modelB = '0;
    cpuAddr      expAddr [$];
    cpuData      expData [$];
    logic [15:0] lfsrState = 16'd39;
    int          errors = 0;
    int          checks = 0;
    int          cycleCount = 0;

    cpuTop UUT (
        .CLK        (CLK),
        .RESET      (RESET),
        .dataIn     (dataIn),
        .romData    (romData),
        .irqRaise   (irqRaise),
        .busAddr    (busAddr),
        .romAddress (romAddress),
        .dataOut    (dataOut),
        .busWe      (busWe),
        .irqAck     (irqAck)
    );

    // 20 ns period
    always #10 CLK = ~CLK;

    ////////////////////////////////////////////////////////////
    // Registered ROM with the byte one cycle after its address
    always @(posedge CLK) begin
        romData <= rom[romAddress];
    end

    // RAM with a one cycle read and a write on the strobe
    always @(posedge CLK) begin
        dataIn <= ram[busAddr];
        if (busWe) begin
            ram[busAddr] <= dataOut;
        end
    end

    // Watchdog
    always @(posedge CLK) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= MAX_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("TESTS FAILED");
            $finish;
        end
    end

    task automatic reportMismatch(input string what);
        errors++;
        $display("Fail at %0d ns: %s", $time, what);
    endtask

    // Every bus write is matched against the next predicted one
    always @(negedge CLK) begin
        if (!RESET && busWe) begin
            checks++;
            if (expAddr.size() == 0) begin
                errors++;
                $display("Bus write to %h at %0d ns when no write was expected",
                         busAddr, $time);
            end else begin
                if (busAddr !== expAddr[0] || dataOut !== expData[0]) begin
                    reportMismatch($sformatf("write %h to %h, expected %h to %h",
                                             dataOut, busAddr, expData[0], expAddr[0]));
                end
                void'(expAddr.pop_front());
                void'(expData.pop_front());
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Random numbers
    // Fibonacci LFSR with taps for x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsrNext(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    // One LFSR step per bit taken
    function automatic cpuData randBits(input int n);
        cpuData v;
        int     k;
        v = '0;
        for (k = 0; k < n; k++) begin
            lfsrState = lfsrNext(lfsrState);
            v = {v[6:0], lfsrState[0]};
        end
        return v;
    endfunction

    // ALU behavior as listed for the instruction set
    function automatic cpuData aluModel(input logic [3:0] op, input cpuData a, input cpuData b);
        case (op)
            aluAdd:  return a + b;
            aluSub:  return a - b;
            aluAnd:  return a & b;
            aluOr:   return a | b;
            aluXor:  return a ^ b;
            aluShl:  return {a[6:0], 1'b0};
            aluShr:  return {1'b0, a[7:1]};
            aluIncA: return a + 8'd1;
            aluEq:   return (a == b) ? 8'd1 : 8'd0;
            aluGt:   return (a > b) ? 8'd1 : 8'd0;
            aluLt:   return (a < b) ? 8'd1 : 8'd0;
            default: return a;
        endcase
    endfunction

    // B variants of an instruction sit one code above the A variants
    function automatic cpuData encodeOp(input logic [3:0] hi, input cpuOpcode code,
                                        input logic selB);
        logic [3:0] low;
        low = code;
        low[0] = low[0] | selB;
        return {hi, low};
    endfunction

    ////////////////////////////////////////////////////////////
    // Program assembly
    task automatic buildProgram(input cpuAddr start);
        cpuAddr     at;
        cpuData     r;
        cpuData     arg;
        cpuData     fillAddr;
        logic [3:0] cmpOp;
        int         count;
        int         i;
        // Unused ROM holds undecoded codes that vary with the address
        for (i = 0; i < 256; i++) begin
            fillAddr = cpuData'(i);
            rom[i] = {fillAddr[7:4] ^ fillAddr[3:0], 4'hF};
        end
        // PC is 0 after reset and goes straight to idle
        rom[0] = encodeOp(4'h0, opIdle, 1'b0);
        at = start;
        count = 6 + randBits(3);
        for (i = 0; i < count; i++) begin
            r = randBits(8);
            arg = randBits(8);
            case (r[2:1])
                2'd0: begin
                    // Read from anywhere in RAM
                    rom[at] = encodeOp(r[7:4], opReadA, r[0]);
                    rom[at + 1] = arg;
                    at = at + 8'd2;
                end
                2'd1: begin
                    // Any high nibble including the pass-through codes
                    rom[at] = encodeOp(r[7:4], opMathA, r[0]);
                    at = at + 8'd1;
                end
                2'd2: begin
                    // Writes land in the upper quarter
                    rom[at] = encodeOp(r[7:4], opWriteA, r[0]);
                    rom[at + 1] = {2'b11, arg[5:0]};
                    at = at + 8'd2;
                end
                default: begin
                    // Eq, Gt or Lt compare
                    // A taken branch skips the write behind it
                    cmpOp = (r[5:4] == 2'd3) ? 4'h8 : {2'b10, r[5:4]};
                    rom[at] = encodeOp(cmpOp, opBranch, 1'b0);
                    rom[at + 1] = at + 8'd4;
                    rom[at + 2] = encodeOp(arg[7:4], opWriteA, r[0]);
                    rom[at + 3] = {2'b11, arg[5:0]};
                    at = at + 8'd4;
                end
            endcase
        end
        // Goto jumps over a write that must never show
        rom[at] = encodeOp(r[7:4], opGoto, 1'b0);
        rom[at + 1] = at + 8'd4;
        rom[at + 2] = encodeOp(4'h0, opWriteA, 1'b0);
        rom[at + 3] = 8'hC0;
        // Closing write from B then idle
        rom[at + 4] = encodeOp(4'h0, opWriteA, 1'b1);
        rom[at + 5] = 8'hFE;
        rom[at + 6] = encodeOp(r[3:0], opIdle, 1'b0);
    endtask

    // Instruction-level interpreter that queues the expected writes
    task automatic runModel(input cpuAddr start);
        cpuAddr pc;
        cpuData op;
        cpuData arg;
        int     steps;
        pc = start;
        modelRam = ram;
        for (steps = 0; steps < 200; steps++) begin
            op = rom[pc];
            arg = rom[cpuAddr'(pc + 8'd1)];
            case (op[3:0])
                opReadA: modelA = modelRam[arg];
                opReadB: modelB = modelRam[arg];
                opWriteA, opWriteB: begin
                    expAddr.push_back(arg);
                    expData.push_back(op[0] ? modelB : modelA);
                    modelRam[arg] = op[0] ? modelB : modelA;
                end
                opMathA: modelA = aluModel(op[7:4], modelA, modelB);
                opMathB: modelB = aluModel(op[7:4], modelA, modelB);
                default: ;
            endcase
            // Next instruction address
            if (op[3:0] == opIdle) begin
                break;
            end else if (op[3:0] == opGoto) begin
                pc = arg;
            end else if (op[3:0] == opBranch && aluModel(op[7:4], modelA, modelB) != 0) begin
                pc = arg;
            end else if (op[3:0] == opMathA || op[3:0] == opMathB) begin
                pc = pc + 8'd1;
            end else begin
                pc = pc + 8'd2;
            end
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Main sequence
    initial begin
        cpuAddr start;
        cpuData r;
        cpuIrq  line;
        cpuIrq  wantAck;
        int     idleRun;
        int     i;
        int     t;
        RESET = 1'b1;
        irqRaise = '0;
        dataIn = '0;
        romData = '0;
        for (i = 0; i < 256; i++) begin
            ram[i] = ~cpuData'(i);
        end
        buildProgram(8'h10);
        repeat (2) @(posedge CLK);
        RESET <= 1'b0;

        // Quiet bus before the first interrupt
        repeat (5) begin
            @(negedge CLK);
            checks++;
            if (busWe !== 1'b0 || irqAck !== '0 || busAddr !== `CPU_BUS_IDLE_ADDR) begin
                reportMismatch($sformatf("after reset busWe %b irqAck %b busAddr %h",
                                         busWe, irqAck, busAddr));
            end
        end

        for (t = 0; t < TRIALS; t++) begin
            @(negedge CLK);
            for (i = 0; i < 256; i++) begin
                ram[i] = randBits(8);
            end
            start = 8'h04 + randBits(7);
            buildProgram(start);
            r = randBits(2);
            line = (r[1:0] == 2'b00) ? 2'b11 : r[1:0];
            // Line 0 wins when both are raised
            wantAck = line[0] ? 2'b01 : 2'b10;
            // Losing vector points at the idle byte at 0
            rom[`CPU_IRQ0_VECTOR] = line[0] ? start : 8'h00;
            rom[`CPU_IRQ1_VECTOR] = line[0] ? 8'h00 : start;
            runModel(start);

            @(posedge CLK);
            irqRaise <= line;
            @(negedge CLK);
            while (irqAck == '0) begin
                @(negedge CLK);
            end
            checks++;
            if (irqAck !== wantAck) begin
                reportMismatch($sformatf("irqAck %b for raise %b, expected %b",
                                         irqAck, line, wantAck));
            end
            @(posedge CLK);
            irqRaise <= '0;
            @(negedge CLK);
            checks++;
            if (irqAck !== '0) begin
                reportMismatch($sformatf("irqAck %b one cycle after acknowledge", irqAck));
            end

            // Thread done once the ROM address sits on the vector
            idleRun = 0;
            while (idleRun < 4) begin
                @(negedge CLK);
                if (romAddress == `CPU_IRQ0_VECTOR) begin
                    idleRun++;
                end else begin
                    idleRun = 0;
                end
            end
            checks++;
            if (expAddr.size() != 0) begin
                errors++;
                $display("Trial %0d ended with %0d predicted writes missing", t, expAddr.size());
            end
            expAddr.delete();
            expData.delete();
            // Any write in the idle gap is flagged by the monitor
            repeat (2 + randBits(3)) @(negedge CLK);
        end

        $display("Checks %0d, value errors %0d, assertion failures %0d",
                 checks, errors, UUT.chk0.assertFails);
        if (errors == 0 && UUT.chk0.assertFails == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- cpuTop.sv
`timescale 1ns/100ps

module cpuTop (
    input  logic              CLK,
    input  logic              RESET,
    input  cpuBusPkg::cpuData dataIn,
    input  cpuBusPkg::cpuData romData,
    input  cpuBusPkg::cpuIrq  irqRaise,
    output cpuBusPkg::cpuAddr busAddr,
    output cpuBusPkg::cpuAddr romAddress,
    output cpuBusPkg::cpuData dataOut,
    output logic              busWe,
    output cpuBusPkg::cpuIrq  irqAck
);
    import cpuIsaPkg::*;

    // Sequencer to program counter
    pcAction pcCtrl;
    logic    offset;

    // Sequencer to datapath
    logic    regLoadA;
    logic    regLoadB;
    logic    loadFromBus;
    logic    busAddrFromRom;
    logic    writeStrobe;
    logic    writeSelB;
    logic    branchTaken;

    cpuControl control0 (
        .CLK            (CLK),
        .RESET          (RESET),
        .romData        (romData),
        .irqRaise       (irqRaise),
        .branchTaken    (branchTaken),
        .pcCtrl         (pcCtrl),
        .offset         (offset),
        .regLoadA       (regLoadA),
        .regLoadB       (regLoadB),
        .loadFromBus    (loadFromBus),
        .busAddrFromRom (busAddrFromRom),
        .writeStrobe    (writeStrobe),
        .writeSelB      (writeSelB),
        .irqAck         (irqAck)
    );

    programCounter pc0 (
        .CLK        (CLK),
        .RESET      (RESET),
        .pcCtrl     (pcCtrl),
        .offset     (offset),
        .romData    (romData),
        .romAddress (romAddress)
    );

    cpuDatapath datapath0 (
        .CLK            (CLK),
        .RESET          (RESET),
        .romData        (romData),
        .dataIn         (dataIn),
        .regLoadA       (regLoadA),
        .regLoadB       (regLoadB),
        .loadFromBus    (loadFromBus),
        .busAddrFromRom (busAddrFromRom),
        .writeStrobe    (writeStrobe),
        .writeSelB      (writeSelB),
        .busAddr        (busAddr),
        .dataOut        (dataOut),
        .busWe          (busWe),
        .branchTaken    (branchTaken)
    );

endmodule

//--- cpu_chk.sv
`timescale 1ns/100ps
`include "cpu_config.svh"

module cpuChk (
    input logic               CLK,
    input logic               RESET,
    input cpuBusPkg::cpuAddr  busAddr,
    input logic               busWe,
    input cpuIsaPkg::cpuState ctrlState,
    input cpuBusPkg::cpuIrq   irqAck
);
    import cpuIsaPkg::*;

    // Count of failed assertions
    int assertFails = 0;

    ////////////////////////////////////////////////////////////
    // Interrupt acknowledge
    // At most one line acknowledged at a time
    ackOneHot: assert property (@(posedge CLK) disable iff (RESET) $onehot0(irqAck))
        else begin
            assertFails++;
            $error("irqAck has more than one line set: %b", irqAck);
        end

    // Acknowledge lasts a single cycle
    ackSingle: assert property (@(posedge CLK) disable iff (RESET)
        (irqAck != '0) |=> (irqAck == '0))
        else begin
            assertFails++;
            $error("irqAck stayed high for more than one cycle");
        end

    ////////////////////////////////////////////////////////////
    // Data bus
    // Write strobe is a one cycle pulse
    weSingle: assert property (@(posedge CLK) disable iff (RESET) busWe |=> !busWe)
        else begin
            assertFails++;
            $error("busWe high in two cycles in a row");
        end

    // Only a write or the read address cycle may leave the idle address
    addrIdle: assert property (@(posedge CLK) disable iff (RESET)
        (!busWe && ctrlState != stRead1) |-> (busAddr == `CPU_BUS_IDLE_ADDR))
        else begin
            assertFails++;
            $error("busAddr is %h outside an access", busAddr);
        end

endmodule

bind cpuTop cpuChk chk0 (
    .CLK       (CLK),
    .RESET     (RESET),
    .busAddr   (busAddr),
    .busWe     (busWe),
    .ctrlState (control0.state),
    .irqAck    (irqAck)
);

//--- cpu_config.svh
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

// Width of data bus, registers and ROM addresses
`define CPU_DATA_WIDTH 8

// Number of interrupt lines
// Line 0 wins when both are raised
`define CPU_IRQ_COUNT 2

// ROM locations that hold the thread start address for each line
`define CPU_IRQ0_VECTOR 8'hFF
`define CPU_IRQ1_VECTOR 8'hFE

// Bus address shown whenever no access is in progress
`define CPU_BUS_IDLE_ADDR 8'hFF

// Program counter steps
// Short step for one byte instructions, long step skips the address byte
`define CPU_PC_STEP_SHORT 8'd1
`define CPU_PC_STEP_LONG 8'd2

`endif

//--- programCounter.sv
`timescale 1ns/100ps
`include "cpu_config.svh"

module programCounter (
    input  logic               CLK,
    input  logic               RESET,
    input  cpuIsaPkg::pcAction pcCtrl,
    input  logic               offset,
    input  cpuBusPkg::cpuData  romData,
    output cpuBusPkg::cpuAddr  romAddress
);
    import cpuBusPkg::*;
    import cpuIsaPkg::*;

    // Points at the current instruction byte
    cpuAddr pc;
    // Set while the second byte of an instruction is fetched
    logic   offsetReg;

    // ROM address is the counter plus the fetch offset
    assign romAddress = pc + cpuAddr'(offsetReg);

    always_ff @(posedge CLK) begin
        if (RESET) begin
            pc        <= '0;
            offsetReg <= 1'b0;
        end else begin
            offsetReg <= offset;
            case (pcCtrl)
                // Jump target or thread start from ROM
                pcLoadRom: pc <= romData;
                // Past a one byte instruction
                pcStep1:   pc <= pc + `CPU_PC_STEP_SHORT;
                // Past a two byte instruction
                pcStep2:   pc <= pc + `CPU_PC_STEP_LONG;
                // Interrupt vector locations
                pcVector0: pc <= `CPU_IRQ0_VECTOR;
                pcVector1: pc <= `CPU_IRQ1_VECTOR;
                default:   pc <= pc;
            endcase
        end
    end

endmodule
